//--- filelist.f
source/spi_bridge_pkg.sv
source/bus_if.sv
source/spi_pin_sync.sv
source/spi_bit_counter.sv
source/spi_shifter.sv
source/spi_cmd_fsm.sv
source/bus_ram.sv
source/spi_bridge_top.sv
tb/spi_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for a pass

cd "$(dirname "$0")" || exit 1
set -o pipefail

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module spi_bridge_tb \
    -o spi_bridge_sim \
    && ./obj_dir/spi_bridge_sim | tee sim.log \
    || echo "Build or simulation stopped with an error"

grep -q "^TEST RESULT: PASS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- source/bus_if.sv
// ==========================================================
// Byte bus with a cycle/ack handshake. The target acks once
// per cycle; the master holds addr, we and wdata until then.
// ==========================================================

`timescale 1ns/1ps

interface bus_if;
    import spi_bridge_pkg::*;

    logic [addr_w-1:0] addr;
    logic [byte_w-1:0] wdata;
    logic              we;
    logic              cycle;
    logic [byte_w-1:0] rdata;
    logic              ack;

    modport master (
        output addr,
        output wdata,
        output we,
        output cycle,
        input  rdata,
        input  ack
    );

    modport target (
        input  addr,
        input  wdata,
        input  we,
        input  cycle,
        output rdata,
        output ack
    );

endinterface

//--- source/bus_ram.sv
// ==========================================================
// Byte memory on the bus, 2**ram_addr_bits deep and zero at
// power-up. Upper address bits are ignored. Acks once per
// cycle, one clock after cycle is first seen.
// ==========================================================

`timescale 1ns/1ps

module bus_ram (
    input  logic  clock,
    input  logic  rst_n_i,
    bus_if.target bus
);
    import spi_bridge_pkg::*;

    logic [byte_w-1:0]        mem [ram_depth];
    logic [ram_addr_bits-1:0] index;
    logic [byte_w-1:0]        rdata_q;
    logic                     ack_q;
    logic                     served_q;    // Cycle already answered
    logic                     access;

    initial begin
        for (int i = 0; i < ram_depth; i++) begin
            mem[i] = '0;
        end
    end

    assign index  = bus.addr[ram_addr_bits-1:0];
    assign access = bus.cycle && !served_q;   // First clock of a cycle

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_q    <= access;
            served_q <= bus.cycle;   // Clears once the master drops cycle
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            if (bus.we) mem[index] <= bus.wdata;
            rdata_q <= mem[index];
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ack   = ack_q;

    a_ack_after_cycle: assert property (@(posedge clock) disable iff (!rst_n_i)
        bus.ack |-> $past(bus.cycle));

endmodule

//--- source/spi_bit_counter.sv
// ==========================================================
// Bit position within the current byte. Restarts at every
// frame start. The host must not clock sck before the first
// frame, which the assertion below watches.
// ==========================================================

`timescale 1ns/1ps

module spi_bit_counter (
    input  logic       clock,
    input  logic       rst_n_i,
    input  logic       sck_rise_i,
    input  logic       cs_start_i,
    output logic [2:0] bit_index_o,
    output logic       byte_done_o
);

    logic [2:0] count_q;
    logic       armed_q;    // Set by the first frame start
    logic       done_q;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            count_q <= '0;
            armed_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (cs_start_i) begin
                count_q <= '0;
                armed_q <= 1'b1;
            end else if (sck_rise_i) begin
                count_q <= count_q + 3'd1;
                done_q  <= (count_q == 3'd7);   // Wraps after bit 8
            end
        end
    end

    assign bit_index_o = count_q;
    assign byte_done_o = done_q;

    // No byte may complete before the first frame has started
    a_done_in_frame: assert property (@(posedge clock) disable iff (!rst_n_i)
        byte_done_o |-> armed_q);

endmodule

//--- source/spi_bridge_pkg.sv
// ==========================================================
// Shared widths and encodings for the SPI bridge.
// Addresses are 17 bits. The on-chip memory decodes only the
// low ram_addr_bits, so higher addresses alias onto it.
// ==========================================================

package spi_bridge_pkg;

    localparam int unsigned byte_w        = 8;
    localparam int unsigned addr_w        = 17;
    localparam int unsigned ram_addr_bits = 10;
    localparam int unsigned ram_depth     = 1 << ram_addr_bits;

    // Command opcode in bits 7:6 of the first frame byte
    typedef enum logic [1:0] {
        op_none      = 2'b00,   // Frame ignored until cs_n rises
        op_write_at  = 2'b01,
        op_read_at   = 2'b10,
        op_read_next = 2'b11
    } opcode_t;

    // First byte of a frame is a command, every later byte is data
    typedef union packed {
        struct packed {
            opcode_t    opcode;     // Bits 7:6
            logic [4:0] reserved;   // Ignored
            logic       addr_msb;   // Address bit 16
        } cmd;
        logic [byte_w-1:0] raw;
    } spi_cmd_u;

endpackage

//--- source/spi_bridge_top.sv
// ==========================================================
// SPI to byte-bus bridge with the memory inside. SPI mode 0,
// MSB first, cs_n active low. The host polls spi_stall_o
// before further sck edges or ending a write frame.
// ==========================================================

`timescale 1ns/1ps

module spi_bridge_top (
    input  logic clock,
    input  logic rst_n_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic spi_poci_o,
    output logic spi_stall_o
);
    import spi_bridge_pkg::*;

    logic       sck_rise;
    logic       sck_fall;
    logic       cs_start;
    logic       cs_end;
    logic       pico_s;
    logic       byte_done;
    spi_cmd_u   rx_byte;
    logic [7:0] tx_byte;
    logic       tx_load;

    bus_if i_bus ();

    spi_pin_sync i_pin_sync (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_pico_i (spi_pico_i),
        .sck_rise_o (sck_rise),
        .sck_fall_o (sck_fall),
        .cs_start_o (cs_start),
        .cs_end_o   (cs_end),
        .pico_o     (pico_s),
        .selected_o ()
    );

    spi_bit_counter i_bit_counter (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .sck_rise_i  (sck_rise),
        .cs_start_i  (cs_start),
        .bit_index_o (),
        .byte_done_o (byte_done)
    );

    spi_shifter i_shifter (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .sck_rise_i (sck_rise),
        .sck_fall_i (sck_fall),
        .pico_i     (pico_s),
        .tx_load_i  (tx_load),
        .tx_byte_i  (tx_byte),
        .rx_byte_o  (rx_byte),
        .spi_poci_o (spi_poci_o)
    );

    spi_cmd_fsm i_cmd_fsm (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .byte_done_i (byte_done),
        .cs_start_i  (cs_start),
        .cs_end_i    (cs_end),
        .rx_byte_i   (rx_byte),
        .bus         (i_bus.master),
        .tx_byte_o   (tx_byte),
        .tx_load_o   (tx_load),
        .stall_o     (spi_stall_o)
    );

    bus_ram i_bus_ram (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .bus     (i_bus.target)
    );

endmodule

//--- source/spi_cmd_fsm.sv
// ==========================================================
// Frame decoder and bus master. Stall is high while a bus
// cycle is pending. cs_n rising aborts at once, and an aborted
// write may or may not reach the memory.
// ==========================================================

`timescale 1ns/1ps

module spi_cmd_fsm (
    input  logic                     clock,
    input  logic                     rst_n_i,
    input  logic                     byte_done_i,
    input  logic                     cs_start_i,
    input  logic                     cs_end_i,
    input  spi_bridge_pkg::spi_cmd_u rx_byte_i,
    bus_if.master                    bus,
    output logic [7:0]               tx_byte_o,
    output logic                     tx_load_o,
    output logic                     stall_o
);
    import spi_bridge_pkg::*;

    enum logic [2:0] {
        idle,
        cmd,
        addr_hi,
        addr_lo,
        wdata,
        bus_wait,
        respond
    } state_q;

    logic [addr_w-1:0] addr_q;     // Last address used, base of read_next
    logic [addr_w-1:0] stage_q;    // Header address being collected
    logic [byte_w-1:0] wdata_q;
    logic              we_q;
    logic              cycle_q;
    logic              stall_q;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q <= idle;
            addr_q  <= '0;
            we_q    <= 1'b0;
            cycle_q <= 1'b0;
            stall_q <= 1'b0;
        end else if (cs_end_i) begin
            state_q <= idle;       // Abort from any state
            cycle_q <= 1'b0;
            stall_q <= 1'b0;
        end else begin
            unique case (state_q)
                idle: begin
                    if (cs_start_i) state_q <= cmd;
                end
                cmd: begin
                    if (byte_done_i) begin
                        unique case (rx_byte_i.cmd.opcode)
                            op_write_at, op_read_at: begin
                                we_q    <= (rx_byte_i.cmd.opcode == op_write_at);
                                state_q <= addr_hi;
                            end
                            op_read_next: begin
                                addr_q  <= addr_q + addr_w'(1);   // Carries into bit 16
                                we_q    <= 1'b0;
                                cycle_q <= 1'b1;
                                stall_q <= 1'b1;
                                state_q <= bus_wait;
                            end
                            default: state_q <= respond;    // op_none, sit out the frame
                        endcase
                    end
                end
                addr_hi: begin
                    if (byte_done_i) state_q <= addr_lo;
                end
                addr_lo: begin
                    if (byte_done_i) begin
                        if (we_q) begin
                            state_q <= wdata;
                        end else begin
                            addr_q  <= {stage_q[addr_w-1:byte_w], rx_byte_i.raw};
                            cycle_q <= 1'b1;
                            stall_q <= 1'b1;
                            state_q <= bus_wait;
                        end
                    end
                end
                wdata: begin
                    if (byte_done_i) begin
                        addr_q  <= stage_q;   // Committed only once the write starts
                        cycle_q <= 1'b1;
                        stall_q <= 1'b1;
                        state_q <= bus_wait;
                    end
                end
                bus_wait: begin
                    if (bus.ack) begin
                        cycle_q <= 1'b0;
                        stall_q <= 1'b0;   // Response byte loads on this clock
                        state_q <= respond;
                    end
                end
                respond: ;                 // Host clocks out the response, wait for cs_end
                default: state_q <= idle;
            endcase
        end
    end

    // Header bytes land in the staging register
    always_ff @(posedge clock) begin
        if (byte_done_i) begin
            case (state_q)
                cmd:     stage_q[addr_w-1]        <= rx_byte_i.cmd.addr_msb;
                addr_hi: stage_q[addr_w-2:byte_w] <= rx_byte_i.raw;
                addr_lo: stage_q[byte_w-1:0]      <= rx_byte_i.raw;
                wdata:   wdata_q                  <= rx_byte_i.raw;
                default: ;
            endcase
        end
    end

    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.we    = we_q;
    assign bus.cycle = cycle_q;

    assign tx_byte_o = bus.rdata;
    assign tx_load_o = (state_q == bus_wait) && bus.ack && !we_q;
    assign stall_o   = stall_q;

    a_req_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
        bus.cycle && !bus.ack |=> $stable(bus.addr) && $stable(bus.we) && $stable(bus.wdata));

    a_stall_covers_cycle: assert property (@(posedge clock) disable iff (!rst_n_i)
        bus.cycle |-> stall_o);

endmodule

//--- source/spi_pin_sync.sv
// ==========================================================
// All clock-domain crossing of the SPI pins lives here.
// Strobes lag the pins by 3 clocks, so the host must hold
// each sck phase for at least 4 clocks.
// ==========================================================

`timescale 1ns/1ps

module spi_pin_sync (
    input  logic clock,
    input  logic rst_n_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic sck_rise_o,
    output logic sck_fall_o,
    output logic cs_start_o,
    output logic cs_end_o,
    output logic pico_o,
    output logic selected_o
);

    // Stage 0 and 1 synchronize, stage 2 is the edge reference
    logic [2:0] sck_q;
    logic [2:0] cs_n_q;
    logic [2:0] pico_q;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            sck_q  <= '0;
            cs_n_q <= '1;    // Deselected, no false cs_start
            pico_q <= '0;
        end else begin
            sck_q  <= {sck_q[1:0], spi_sck_i};
            cs_n_q <= {cs_n_q[1:0], spi_cs_n_i};
            pico_q <= {pico_q[1:0], spi_pico_i};
        end
    end

    assign sck_rise_o = sck_q[1] & ~sck_q[2];
    assign sck_fall_o = ~sck_q[1] & sck_q[2];

    // cs_n falling opens a frame, rising closes it
    assign cs_start_o = ~cs_n_q[1] & cs_n_q[2];
    assign cs_end_o   = cs_n_q[1] & ~cs_n_q[2];

    // One clock older than the sck edge, pico is long settled by then
    assign pico_o     = pico_q[2];
    assign selected_o = ~cs_n_q[2];

endmodule

//--- source/spi_shifter.sv
// ==========================================================
// SPI mode 0 data path, MSB first. Input is sampled on sck
// rise and output changes on sck fall. tx_load shows bit 7
// at once, before the first rise of the response byte.
// ==========================================================

`timescale 1ns/1ps

module spi_shifter (
    input  logic                     clock,
    input  logic                     rst_n_i,
    input  logic                     sck_rise_i,
    input  logic                     sck_fall_i,
    input  logic                     pico_i,
    input  logic                     tx_load_i,
    input  logic [7:0]               tx_byte_i,
    output spi_bridge_pkg::spi_cmd_u rx_byte_o,
    output logic                     spi_poci_o
);
    import spi_bridge_pkg::*;

    logic [byte_w-1:0] rx_q;
    logic [byte_w-1:0] tx_q;
    logic              rise_seen_q;    // Current POCI bit was sampled

    always_ff @(posedge clock) begin
        if (sck_rise_i) begin
            rx_q <= {rx_q[byte_w-2:0], pico_i};
        end
    end

    // A fall only advances POCI once the host has sampled the bit,
    // so the trailing fall of the previous byte leaves bit 7 in place
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            tx_q        <= '0;
            rise_seen_q <= 1'b0;
        end else if (tx_load_i) begin
            tx_q        <= tx_byte_i;
            rise_seen_q <= 1'b0;
        end else if (sck_rise_i) begin
            rise_seen_q <= 1'b1;
        end else if (sck_fall_i && rise_seen_q) begin
            tx_q        <= {tx_q[byte_w-2:0], 1'b0};
            rise_seen_q <= 1'b0;
        end
    end

    assign rx_byte_o  = rx_q;      // Valid with byte_done
    assign spi_poci_o = tx_q[byte_w-1];

endmodule

//--- tb/spi_bridge_tb.sv
// ==========================================================
// Testbench for the SPI bridge. The host runs mode 0 with
// 4-clock sck phases and polls stall before response bits.
// Reads are checked against a reference memory model.
// ==========================================================

`timescale 1ns/1ps

module spi_bridge_tb;
    import spi_bridge_pkg::*;

    localparam int sck_phase   = 4;     // Clocks per sck phase
    localparam int frame_gap   = 8;     // Idle clocks between frames
    localparam int stall_limit = 20;
    localparam int n_random    = 200;

    logic clock = 1'b0;
    logic rst_n;
    logic spi_sck;
    logic spi_cs_n;
    logic spi_pico;
    logic spi_poci;
    logic spi_stall;

    opcode_t           op_tab[$];
    logic [addr_w-1:0] addr_tab[$];
    logic [7:0]        data_tab[$];
    int                abort_tab[$];    // Bits sent before cs_n rises, 0 for a full frame
    int                exp_tab[$];      // Fixed read byte, -1 takes the model
    string             name_tab[$];

    logic [7:0]        ref_mem [ram_depth];
    logic [addr_w-1:0] prev_addr;       // Base of read_next
    int                stall_total   = 0;
    int                stall_run     = 0;
    int                cycle_count   = 0;
    int                timeout_limit = 1000;

    spi_bridge_top i_spi_bridge_top (
        .clock       (clock),
        .rst_n_i     (rst_n),
        .spi_sck_i   (spi_sck),
        .spi_cs_n_i  (spi_cs_n),
        .spi_pico_i  (spi_pico),
        .spi_poci_o  (spi_poci),
        .spi_stall_o (spi_stall)
    );

    always #20 clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Counts stall clocks and bounds every stall window
    always @(negedge clock) begin
        if (spi_stall) begin
            stall_total = stall_total + 1;
            stall_run   = stall_run + 1;
            if (stall_run > stall_limit) fail_run("Stall stayed high for more than 20 clocks");
        end else begin
            stall_run = 0;
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            fail_run($sformatf("Timeout, the run did not finish in %0d clocks", timeout_limit));
        end
    end

    task automatic add_op(input string name, input opcode_t op, input logic [addr_w-1:0] addr,
                          input logic [7:0] data, input int abort_bits, input int expected);
        name_tab.push_back(name);
        op_tab.push_back(op);
        addr_tab.push_back(addr);
        data_tab.push_back(data);
        abort_tab.push_back(abort_bits);
        exp_tab.push_back(expected);
    endtask

    task automatic load_directed_ops;
        add_op("fresh read 0x00000", op_read_at,   17'h00000, 8'h00,  0, 'h00);
        add_op("fresh read 0x003ff", op_read_at,   17'h003ff, 8'h00,  0, 'h00);
        add_op("fresh read_next",    op_read_next, 17'h00000, 8'h00,  0, 'h00);
        add_op("write 0x00010",      op_write_at,  17'h00010, 8'ha5,  0, -1);
        add_op("read back 0x00010",  op_read_at,   17'h00010, 8'h00,  0, 'ha5);
        add_op("alias read 0x10410", op_read_at,   17'h10410, 8'h00,  0, 'ha5);
        add_op("write 0x00020",      op_write_at,  17'h00020, 8'h11,  0, -1);
        add_op("write 0x00021",      op_write_at,  17'h00021, 8'h22,  0, -1);
        add_op("write 0x00022",      op_write_at,  17'h00022, 8'h33,  0, -1);
        add_op("write 0x0001f",      op_write_at,  17'h0001f, 8'h5c,  0, -1);
        add_op("read_next 0x00020",  op_read_next, 17'h00000, 8'h00,  0, 'h11);
        add_op("read_next 0x00021",  op_read_next, 17'h00000, 8'h00,  0, 'h22);
        add_op("read_next 0x00022",  op_read_next, 17'h00000, 8'h00,  0, 'h33);
        add_op("write 0x0ffff",      op_write_at,  17'h0ffff, 8'h77,  0, -1);
        add_op("write 0x10000",      op_write_at,  17'h10000, 8'h9e,  0, -1);
        add_op("read 0x0fffe",       op_read_at,   17'h0fffe, 8'h00,  0, 'h00);
        add_op("read_next 0x0ffff",  op_read_next, 17'h00000, 8'h00,  0, 'h77);
        add_op("read_next carry",    op_read_next, 17'h00000, 8'h00,  0, 'h9e);
        add_op("read 0x1ffff",       op_read_at,   17'h1ffff, 8'h00,  0, 'h77);
        add_op("read_next wrap",     op_read_next, 17'h00000, 8'h00,  0, 'h9e);
        add_op("write 0x00040",      op_write_at,  17'h00040, 8'h3c,  0, -1);
        add_op("abort in address",   op_write_at,  17'h00040, 8'hc3, 20, -1);
        add_op("abort in data",      op_write_at,  17'h00040, 8'hc3, 30, -1);
        add_op("read after aborts",  op_read_at,   17'h00040, 8'h00,  0, 'h3c);
        add_op("abort read_at",      op_read_at,   17'h0001f, 8'h00, 20, -1);
        add_op("read_next 0x00041",  op_read_next, 17'h00000, 8'h00,  0, 'h00);
        add_op("op_none frame",      op_none,      17'h00020, 8'hff,  0, -1);
        add_op("read_next 0x00042",  op_read_next, 17'h00000, 8'h00,  0, 'h00);
        add_op("read after op_none", op_read_at,   17'h00040, 8'h00,  0, 'h3c);
    endtask

    // Entered and left on a rising clock, sck low, POCI sampled late in the high phase
    task automatic shift_bits(input logic [7:0] tx, input int n_bits, output logic [7:0] rx);
        rx = '0;
        for (int i = 0; i < n_bits; i++) begin
            spi_pico <= tx[7-i];
            repeat (sck_phase) @(posedge clock);
            spi_sck <= 1'b1;
            repeat (sck_phase - 1) @(posedge clock);
            @(negedge clock);
            rx = {rx[6:0], spi_poci};
            @(posedge clock);
            spi_sck <= 1'b0;
        end
    endtask

    task automatic wait_stall_low;
        int waited;
        waited = 0;
        @(negedge clock);
        while (spi_stall) begin
            waited = waited + 1;
            if (waited > stall_limit) fail_run("Stall did not fall within 20 clocks");
            @(negedge clock);
        end
        @(posedge clock);
    endtask

    task automatic end_frame(input string name);
        repeat (sck_phase) @(posedge clock);
        spi_cs_n <= 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        check_equal({name, " stall after cs_n rise"}, 0, 32'(spi_stall));
        repeat (frame_gap) @(posedge clock);
    endtask

    task automatic run_entry(input int idx);
        opcode_t           op;
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] target;
        logic [7:0]        hdr[$];
        logic [7:0]        rx;
        logic [7:0]        expected;
        int                bits_left;
        int                stall_before;
        string             name;

        op   = op_tab[idx];
        addr = addr_tab[idx];
        name = name_tab[idx];
        hdr.push_back({op, 5'b00000, addr[addr_w-1]});
        if (op != op_read_next) begin
            hdr.push_back(addr[15:8]);
            hdr.push_back(addr[7:0]);
        end
        if (op == op_write_at) hdr.push_back(data_tab[idx]);
        target = (op == op_read_next) ? prev_addr + addr_w'(1) : addr;

        @(posedge clock);
        spi_cs_n <= 1'b0;
        repeat (sck_phase) @(posedge clock);
        stall_before = stall_total;
        bits_left    = (abort_tab[idx] > 0) ? abort_tab[idx] : 8 * hdr.size();
        foreach (hdr[i]) begin
            if (bits_left > 0) begin
                shift_bits(hdr[i], (bits_left > 8) ? 8 : bits_left, rx);
                bits_left = bits_left - 8;
            end
        end

        if (abort_tab[idx] == 0 && op != op_none) begin
            repeat (sck_phase) @(posedge clock);    // Low phase after the last fall
            wait_stall_low();
            check_equal({name, " stall raised"}, 1, 32'(stall_total > stall_before));
            prev_addr = target;
            if (op == op_write_at) begin
                ref_mem[target[ram_addr_bits-1:0]] = data_tab[idx];
            end else begin
                shift_bits(8'h00, 8, rx);
                expected = (exp_tab[idx] >= 0) ? 8'(exp_tab[idx])
                                               : ref_mem[target[ram_addr_bits-1:0]];
                check_equal(name, 32'(expected), 32'(rx));
            end
        end
        end_frame(name);
    endtask

    initial begin
        logic [31:0]       rnd;
        logic [addr_w-1:0] addr;
        int                pick;
        opcode_t           op;

        rnd      = $urandom(23);    // Seed once for the whole run
        rst_n    = 1'b0;
        spi_sck  = 1'b0;
        spi_cs_n = 1'b1;
        spi_pico = 1'b0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        prev_addr = '0;

        load_directed_ops();
        for (int i = 0; i < n_random; i++) begin
            rnd  = $urandom;
            pick = $urandom_range(0, 2);
            addr = {rnd[16:10], 6'b000000, rnd[3:0]};   // 16 hot bytes, random alias bits
            op   = (pick == 0) ? op_write_at : (pick == 1) ? op_read_at : op_read_next;
            add_op($sformatf("random %0d", i), op, addr, rnd[31:24], 0, -1);
        end
        timeout_limit = op_tab.size() * 40 * 10 + 1000;

        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_equal("stall after reset", 0, 32'(spi_stall));
        check_equal("poci after reset", 0, 32'(spi_poci));

        foreach (op_tab[i]) run_entry(i);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
